/* e100_alu.sv */
// ################################################
// e100 alu
// arithmetic, logic and shift result plus the
// equal and signed less-than branch flags
// ################################################

`timescale 1ns/1ps

module e100_alu (
    input  e100_pkg::alu_op_t  alu_op,
    input  e100_pkg::word_t    op1,
    input  e100_pkg::word_t    op2,
    output e100_pkg::word_t    result,
    output logic               equal,
    output logic               less
);
    import e100_pkg::*;

    // shift amounts past the word width flush to zero
    logic  shift_over;
    word_t shift_left;
    word_t shift_right;

    assign shift_over  = (op2 >= word_t'(word_width));
    assign shift_left  = shift_over ? '0 : op1 << op2[4:0];
    assign shift_right = shift_over ? '0 : op1 >> op2[4:0];

    always_comb begin
        case (alu_op)
            alu_add: result = op1 + op2;
            alu_sub: result = op1 - op2;
            alu_and: result = op1 & op2;
            alu_or:  result = op1 | op2;
            alu_not: result = ~op1;
            alu_sl:  result = shift_left;
            alu_sr:  result = shift_right;
            default: result = '0;
        endcase
    end

    assign equal = (op1 == op2);
    // two's complement compare
    assign less  = ($signed(op1) < $signed(op2));

endmodule

/* e100_control.sv */
// ################################################
// e100 instruction sequencer
// steps fetch, decode and execute, picks the bus
// source and issues register and memory strobes
// ################################################

`timescale 1ns/1ps

module e100_control (
    input  logic                clock,
    input  logic                reset,
    input  e100_pkg::word_t     opcode,
    input  logic                equal,
    input  logic                less,
    input  logic                mem_done,
    output e100_pkg::bus_src_t  bus_src,
    output e100_pkg::alu_op_t   alu_op,
    output logic                pc_write,
    output logic                opcode_write,
    output logic                arg1_write,
    output logic                arg2_write,
    output logic                arg3_write,
    output logic                op1_write,
    output logic                op2_write,
    output logic                address_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                halted
);
    import e100_pkg::*;

    state_t state;
    state_t next_state;
    // request issued, waiting for mem_done
    logic   pending;
    logic   take_branch;

    always_comb begin
        case (opcode)
            op_sub:  alu_op = alu_sub;
            op_and:  alu_op = alu_and;
            op_or:   alu_op = alu_or;
            op_not:  alu_op = alu_not;
            op_sl:   alu_op = alu_sl;
            op_sr:   alu_op = alu_sr;
            default: alu_op = alu_add;
        endcase
    end

    always_comb begin
        case (opcode)
            op_be:   take_branch = equal;
            op_bne:  take_branch = !equal;
            default: take_branch = less;
        endcase
    end

    always_comb begin
        bus_src       = src_none;
        pc_write      = 1'b0;
        opcode_write  = 1'b0;
        arg1_write    = 1'b0;
        arg2_write    = 1'b0;
        arg3_write    = 1'b0;
        op1_write     = 1'b0;
        op2_write     = 1'b0;
        address_write = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        next_state    = state;

        case (state)
            st_reset: next_state = st_fetch_addr;
            st_fetch_addr: begin
                bus_src = src_pc;
                address_write = 1'b1;
                next_state = st_fetch_op;
            end
            // memory reads: request once, load the target on mem_done
            st_fetch_op, st_fetch_arg1, st_fetch_arg2, st_fetch_arg3,
            st_src1_read, st_src2_read, st_cp_read, st_ret_read: begin
                bus_src = src_mem;
                mem_read = !pending;
                opcode_write = mem_done && state == st_fetch_op;
                arg1_write = mem_done && state == st_fetch_arg1;
                arg2_write = mem_done && state == st_fetch_arg2;
                arg3_write = mem_done && (state == st_fetch_arg3 || state == st_cp_read);
                op1_write = mem_done && state == st_src1_read;
                op2_write = mem_done && state == st_src2_read;
                pc_write = mem_done && state == st_ret_read;
                if (mem_done) begin
                    case (state)
                        st_fetch_op:   next_state = st_fetch_inc1;
                        st_fetch_arg1: next_state = st_fetch_inc2;
                        st_fetch_arg2: next_state = st_fetch_inc3;
                        st_fetch_arg3: next_state = st_decode;
                        st_cp_read:    next_state = st_cp_dst;
                        st_ret_read:   next_state = st_fetch_addr;
                        // not takes a single operand
                        st_src1_read:
                            next_state = (opcode == op_not) ? st_dst_addr : st_src2_addr;
                        default: begin
                            if (opcode == op_be || opcode == op_bne || opcode == op_blt) begin
                                next_state = st_branch;
                            end else begin
                                next_state = st_dst_addr;
                            end
                        end
                    endcase
                end
            end
            // pc advance plus address load
            st_fetch_inc1, st_fetch_inc2, st_fetch_inc3: begin
                bus_src = src_plus1;
                pc_write = 1'b1;
                address_write = 1'b1;
                next_state = state_t'(state + 5'd1);
            end
            st_decode: begin
                bus_src = src_plus1;
                pc_write = 1'b1;
                case (opcode)
                    op_add, op_sub, op_and, op_or, op_not, op_sl, op_sr,
                    op_be, op_bne, op_blt: next_state = st_src1_addr;
                    op_cp:   next_state = st_cp_addr;
                    op_call: next_state = st_call_addr;
                    op_ret:  next_state = st_ret_addr;
                    // halt and anything unknown
                    default: next_state = st_halt;
                endcase
            end
            st_halt: next_state = st_halt;
            st_src1_addr, st_src2_addr, st_dst_addr, st_cp_addr, st_cp_dst,
            st_call_addr, st_ret_addr: begin
                address_write = 1'b1;
                case (state)
                    st_src1_addr: begin
                        bus_src = src_arg2;
                        next_state = st_src1_read;
                    end
                    st_src2_addr: begin
                        bus_src = src_arg3;
                        next_state = st_src2_read;
                    end
                    st_dst_addr: begin
                        bus_src = src_arg1;
                        next_state = st_dst_write;
                    end
                    st_cp_addr: begin
                        bus_src = src_arg2;
                        next_state = st_cp_read;
                    end
                    st_cp_dst: begin
                        bus_src = src_arg1;
                        next_state = st_cp_write;
                    end
                    st_call_addr: begin
                        bus_src = src_arg2;
                        next_state = st_call_write;
                    end
                    default: begin
                        bus_src = src_arg1;
                        next_state = st_ret_read;
                    end
                endcase
            end
            // memory writes: data taken from the bus at request time
            st_dst_write, st_cp_write, st_call_write: begin
                if (state == st_dst_write) begin
                    bus_src = src_alu;
                end else if (state == st_cp_write) begin
                    bus_src = src_arg3;
                end else begin
                    bus_src = src_pc;
                end
                mem_write = !pending;
                if (mem_done) begin
                    next_state = (state == st_call_write) ? st_call_jump : st_fetch_addr;
                end
            end
            st_branch: begin
                bus_src = src_arg1;
                pc_write = take_branch;
                next_state = st_fetch_addr;
            end
            st_call_jump: begin
                bus_src = src_arg1;
                pc_write = 1'b1;
                next_state = st_fetch_addr;
            end
            default: next_state = st_reset;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_reset;
            pending <= 1'b0;
        end else begin
            state <= next_state;
            if (mem_done) begin
                pending <= 1'b0;
            end else if (mem_read || mem_write) begin
                pending <= 1'b1;
            end
        end
    end

    assign halted = (state == st_halt);

    // a completion only answers an issued request
    assert property (@(posedge clock) disable iff (reset) mem_done |-> pending);

    // no transfer left outstanding once halted
    assert property (@(posedge clock) disable iff (reset)
        halted |-> !pending);

endmodule

/* e100_core.f */
e100_pkg.sv
e100_control.sv
e100_registers.sv
e100_alu.sv
e100_wb_master.sv
e100_core.sv
+incdir+.
tb_e100_core.sv

/* e100_core.sv */
// ################################################
// e100 multicycle core
// memory-operand processor with a Wishbone
// classic master port to external memory
// ################################################

`timescale 1ns/1ps

module e100_core (
    input  logic             clock,
    input  logic             reset,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output e100_pkg::addr_t  wb_adr,
    output e100_pkg::word_t  wb_dat_w,
    input  e100_pkg::word_t  wb_dat_r,
    input  logic             wb_ack,
    output logic             halted
);
    import e100_pkg::*;

    bus_src_t bus_src;
    alu_op_t  alu_op;
    word_t    bus;
    word_t    opcode;
    word_t    op1;
    word_t    op2;
    word_t    alu_result;
    word_t    read_data;
    logic     equal;
    logic     less;
    logic     mem_done;
    logic     pc_write;
    logic     opcode_write;
    logic     arg1_write;
    logic     arg2_write;
    logic     arg3_write;
    logic     op1_write;
    logic     op2_write;
    logic     address_write;
    logic     mem_read;
    logic     mem_write;

    e100_control u_control (
        .clock(clock), .reset(reset), .opcode(opcode), .equal(equal), .less(less),
        .mem_done(mem_done), .bus_src(bus_src), .alu_op(alu_op), .pc_write(pc_write),
        .opcode_write(opcode_write), .arg1_write(arg1_write), .arg2_write(arg2_write),
        .arg3_write(arg3_write), .op1_write(op1_write), .op2_write(op2_write),
        .address_write(address_write), .mem_read(mem_read), .mem_write(mem_write),
        .halted(halted)
    );

    e100_registers u_registers (
        .clock(clock), .reset(reset), .bus_src(bus_src), .pc_write(pc_write),
        .opcode_write(opcode_write), .arg1_write(arg1_write), .arg2_write(arg2_write),
        .arg3_write(arg3_write), .op1_write(op1_write), .op2_write(op2_write),
        .read_data(read_data), .alu_result(alu_result), .bus(bus), .opcode(opcode),
        .op1(op1), .op2(op2)
    );

    e100_alu u_alu (
        .alu_op(alu_op), .op1(op1), .op2(op2), .result(alu_result),
        .equal(equal), .less(less)
    );

    e100_wb_master u_wb_master (
        .clock(clock), .reset(reset), .bus(bus), .address_write(address_write),
        .mem_read(mem_read), .mem_write(mem_write), .read_data(read_data),
        .mem_done(mem_done), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

endmodule

/* e100_pkg.sv */
// ################################################
// e100 core shared definitions
// widths, opcodes, bus source selects, alu
// functions and the control state encoding
// ################################################

package e100_pkg;

    localparam int word_width = 32;
    localparam int addr_width = 16;

    typedef logic [word_width-1:0] word_t;
    typedef logic [addr_width-1:0] addr_t;

    // instruction set encodings
    localparam word_t op_halt = 32'd0;
    localparam word_t op_add  = 32'd1;
    localparam word_t op_sub  = 32'd2;
    localparam word_t op_cp   = 32'd5;
    localparam word_t op_and  = 32'd6;
    localparam word_t op_or   = 32'd7;
    localparam word_t op_not  = 32'd8;
    localparam word_t op_sl   = 32'd9;
    localparam word_t op_sr   = 32'd10;
    localparam word_t op_be   = 32'd13;
    localparam word_t op_bne  = 32'd14;
    localparam word_t op_blt  = 32'd15;
    localparam word_t op_call = 32'd16;
    localparam word_t op_ret  = 32'd17;

    typedef enum logic [2:0] {
        src_none, src_pc, src_plus1, src_arg1, src_arg2, src_arg3, src_mem, src_alu
    } bus_src_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_not, alu_sl, alu_sr
    } alu_op_t;

    typedef enum logic [4:0] {
        st_reset, st_fetch_addr, st_fetch_op, st_fetch_inc1, st_fetch_arg1,
        st_fetch_inc2, st_fetch_arg2, st_fetch_inc3, st_fetch_arg3, st_decode,
        st_halt, st_src1_addr, st_src1_read, st_src2_addr, st_src2_read,
        st_dst_addr, st_dst_write, st_branch, st_cp_addr, st_cp_read,
        st_cp_dst, st_cp_write, st_call_addr, st_call_write, st_call_jump,
        st_ret_addr, st_ret_read
    } state_t;

endpackage

/* e100_registers.sv */
// ################################################
// e100 datapath registers
// pc, opcode, argument and operand registers
// plus the internal bus source multiplexer
// ################################################

`timescale 1ns/1ps

module e100_registers (
    input  logic                clock,
    input  logic                reset,
    input  e100_pkg::bus_src_t  bus_src,
    input  logic                pc_write,
    input  logic                opcode_write,
    input  logic                arg1_write,
    input  logic                arg2_write,
    input  logic                arg3_write,
    input  logic                op1_write,
    input  logic                op2_write,
    input  e100_pkg::word_t     read_data,
    input  e100_pkg::word_t     alu_result,
    output e100_pkg::word_t     bus,
    output e100_pkg::word_t     opcode,
    output e100_pkg::word_t     op1,
    output e100_pkg::word_t     op2
);
    import e100_pkg::*;

    word_t pc;
    word_t plus1;
    word_t arg1;
    word_t arg2;
    word_t arg3;

    assign plus1 = pc + word_t'(1);

    // one source on the bus at a time
    always_comb begin
        case (bus_src)
            src_pc:    bus = pc;
            src_plus1: bus = plus1;
            src_arg1:  bus = arg1;
            src_arg2:  bus = arg2;
            src_arg3:  bus = arg3;
            src_mem:   bus = read_data;
            src_alu:   bus = alu_result;
            default:   bus = '0;
        endcase
    end

    // execution starts at word 0
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_write) begin
            pc <= bus;
        end
    end

    always_ff @(posedge clock) begin
        if (opcode_write) begin
            opcode <= bus;
        end
        if (arg1_write) begin
            arg1 <= bus;
        end
        if (arg2_write) begin
            arg2 <= bus;
        end
        if (arg3_write) begin
            arg3 <= bus;
        end
        if (op1_write) begin
            op1 <= bus;
        end
        if (op2_write) begin
            op2 <= bus;
        end
    end

endmodule

/* e100_wb_master.sv */
// ################################################
// e100 memory port
// address register and one Wishbone classic
// read or write per request, waits for ack
// ################################################

`timescale 1ns/1ps

module e100_wb_master (
    input  logic             clock,
    input  logic             reset,
    input  e100_pkg::word_t  bus,
    input  logic             address_write,
    input  logic             mem_read,
    input  logic             mem_write,
    output e100_pkg::word_t  read_data,
    output logic             mem_done,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output e100_pkg::addr_t  wb_adr,
    output e100_pkg::word_t  wb_dat_w,
    input  e100_pkg::word_t  wb_dat_r,
    input  logic             wb_ack
);
    import e100_pkg::*;

    // single transfers only, stb follows cyc
    assign wb_stb = wb_cyc;

    always_ff @(posedge clock) begin
        if (address_write) begin
            wb_adr <= bus[addr_width-1:0];
        end
        if (mem_write) begin
            wb_dat_w <= bus;
        end
        if (wb_cyc && wb_ack) begin
            read_data <= wb_dat_r;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_cyc <= 1'b0;
            wb_we <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (wb_cyc) begin
                if (wb_ack) begin
                    wb_cyc <= 1'b0;
                    wb_we <= 1'b0;
                    mem_done <= 1'b1;
                end
            end else if (mem_read || mem_write) begin
                wb_cyc <= 1'b1;
                wb_we <= mem_write;
            end
        end
    end

    // slave may stall, the request must not move
    assert property (@(posedge clock) disable iff (reset)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w));

    assert property (@(posedge clock) disable iff (reset)
        wb_cyc |-> !(mem_read || mem_write));

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the e100 core testbench with Verilator, runs it and checks the log

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module tb_e100_core \
    -f e100_core.f -o sim_e100 > build.log 2>&1 \
    && ./obj_dir/sim_e100 > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
exit 0

/* tb_e100_model.svh */
// ################################################
// e100 testbench program generator and reference
// instruction set model, included in the testbench
// ################################################

`ifndef TB_E100_MODEL_SVH
`define TB_E100_MODEL_SVH

function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic word_t next_random();
    rand_state = xorshift(rand_state);
    return rand_state;
endfunction

function automatic word_t data_address();
    return word_t'(data_base) + (next_random() % word_t'(64));
endfunction

function automatic word_t alu_model(input word_t op, input word_t a, input word_t b);
    case (op)
        op_sub:  return a - b;
        op_and:  return a & b;
        op_or:   return a | b;
        op_not:  return ~a;
        // full width shift amount, so 32 and above give zero
        op_sl:   return a << b;
        op_sr:   return a >> b;
        default: return a + b;
    endcase
endfunction

function automatic word_t pick_opcode(input int mode);
    word_t r;
    r = next_random() % word_t'(8);
    if (mode == 2 && r < word_t'(2)) begin
        return op_call;
    end
    if (mode == 1) begin
        case (r)
            0: return op_add;
            1: return op_sub;
            2: return op_cp;
            3, 6: return op_be;
            4: return op_bne;
            default: return op_blt;
        endcase
    end
    case (r % word_t'(7))
        0: return op_add;
        1: return op_sub;
        2: return op_and;
        3: return op_or;
        4: return op_not;
        5: return op_sl;
        default: return op_sr;
    endcase
endfunction

// fills image and model_mem with one program
task automatic gen_program(input int mode);
    int i;
    int k;
    int base;
    word_t r;
    word_t op;
    for (i = 0; i < mem_words; i++) begin
        image[i] = (word_t'(i) * 32'h9e3779b1) ^ 32'h0bad0000;
    end
    for (i = data_base; i < data_base + 64; i++) begin
        r = next_random();
        case (r[1:0])
            // shift amounts both below and past the word width
            2'd0: image[i] = r >> 26;
            2'd2: image[i] = word_t'(r[3:0]) - word_t'(8);
            default: image[i] = r;
        endcase
    end
    for (i = 0; i < n_instr; i++) begin
        base = 4 * i;
        op = pick_opcode(mode);
        image[base] = op;
        image[base + 1] = data_address();
        image[base + 2] = data_address();
        image[base + 3] = data_address();
        if (op == op_be || op == op_bne || op == op_blt) begin
            // forward only, up to the final halt
            k = i + 1 + int'(next_random() % word_t'(n_instr - i));
            image[base + 1] = word_t'(4 * k);
            r = next_random();
            if (r[1:0] == 2'd0) begin
                image[base + 3] = image[base + 2];
            end
        end
        if (op == op_call) begin
            image[base + 1] = word_t'(sub_base);
            image[base + 2] = word_t'(ret_slot);
        end
    end
    for (i = 0; i < 4; i++) begin
        image[4 * n_instr + i] = '0;
    end
    if (mode == 3) begin
        image[0] = word_t'(18) + (next_random() % word_t'(16));
    end
    // subroutine: two alu steps, then return through the slot
    image[sub_base] = op_add;
    image[sub_base + 4] = op_sub;
    for (i = 1; i < 4; i++) begin
        image[sub_base + i] = data_address();
        image[sub_base + 4 + i] = data_address();
    end
    image[sub_base + 8] = op_ret;
    image[sub_base + 9] = word_t'(ret_slot);
    model_mem = image;
endtask

task automatic run_model();
    word_t pc;
    word_t op;
    word_t a1;
    word_t a2;
    word_t a3;
    int steps;
    bit running;
    pc = '0;
    running = 1'b1;
    steps = 0;
    while (running && steps < 1000) begin
        op = model_mem[pc[8:0]];
        a1 = model_mem[9'(pc + 1)];
        a2 = model_mem[9'(pc + 2)];
        a3 = model_mem[9'(pc + 3)];
        pc = pc + 4;
        steps++;
        case (op)
            op_add, op_sub, op_and, op_or, op_not, op_sl, op_sr:
                model_mem[a1[8:0]] = alu_model(op, model_mem[a2[8:0]], model_mem[a3[8:0]]);
            op_cp: model_mem[a1[8:0]] = model_mem[a2[8:0]];
            op_be: if (model_mem[a2[8:0]] == model_mem[a3[8:0]]) pc = a1;
            op_bne: if (model_mem[a2[8:0]] != model_mem[a3[8:0]]) pc = a1;
            op_blt: if ($signed(model_mem[a2[8:0]]) < $signed(model_mem[a3[8:0]])) pc = a1;
            op_call: begin
                model_mem[a2[8:0]] = pc;
                pc = a1;
            end
            op_ret: pc = model_mem[a1[8:0]];
            default: running = 1'b0;
        endcase
    end
endtask

`endif

/* tb_e100_core.sv */
// ################################################
// e100 core testbench
// random programs on a Wishbone memory with wait
// states, checked against a reference model
// ################################################

`timescale 1ns/1ps

module tb_e100_core;
    import e100_pkg::*;

    localparam int mem_words = 512;
    localparam int data_base = 256;
    localparam int sub_base = 200;
    localparam int ret_slot = 320;
    localparam int n_instr = 24;
    localparam int run_count = 7;
    // every instruction a call in the worst case
    localparam int max_executed = 4 * n_instr + 1;
    localparam int cycle_limit = run_count * (max_executed * (16 * 4 + 4) + 100);

    logic  clock = 1'b0;
    logic  reset = 1'b1;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    logic  wb_ack = 1'b0;
    logic  halted;
    addr_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r = '0;

    word_t mem [0:mem_words-1];
    word_t image [0:mem_words-1];
    word_t model_mem [0:mem_words-1];
    word_t zero_wait_mem [0:mem_words-1];

    word_t rand_state = 32'h2ee3;
    word_t wait_state = 32'h2ee3;
    int    max_wait = 3;
    int    wait_count = 0;
    int    cycle_count = 0;
    int    error_count = 0;
    int    stall_errors = 0;
    int    errors_at_start;
    int    tests_passed = 0;
    int    tests_failed = 0;

    logic  seen_first;
    addr_t first_adr;
    logic  first_we;
    logic  stall_prev;
    addr_t prev_adr;
    logic  prev_we;
    word_t prev_dat;

    `include "tb_e100_model.svh"

    e100_core u_e100_core (
        .clock(clock), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .halted(halted)
    );

    always #5 clock = ~clock;

    // memory slave, image reloads while reset is high
    always @(posedge clock) begin
        if (reset) begin
            wb_ack <= 1'b0;
            wait_count <= 0;
            mem <= image;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
            wait_state = xorshift(wait_state);
            wait_count <= int'(wait_state % word_t'(max_wait + 1));
        end else if (wb_cyc && wb_stb) begin
            if (wait_count == 0) begin
                wb_ack <= 1'b1;
                wb_dat_r <= mem[wb_adr[8:0]];
                if (wb_we) begin
                    mem[wb_adr[8:0]] <= wb_dat_w;
                end
            end else begin
                wait_count <= wait_count - 1;
            end
        end
    end

    // first access and request stability while ack is held back
    always @(posedge clock) begin
        if (reset) begin
            seen_first = 1'b0;
            stall_prev = 1'b0;
        end else begin
            if (wb_cyc && !seen_first) begin
                seen_first = 1'b1;
                first_adr = wb_adr;
                first_we = wb_we;
            end
            if (stall_prev) begin
                assert (wb_adr === prev_adr && wb_we === prev_we
                    && wb_dat_w === prev_dat) else begin
                    $display("[FAIL] wb_adr %h wb_we %h wb_dat_w %h moved while held at %h %h %h",
                        wb_adr, wb_we, wb_dat_w, prev_adr, prev_we, prev_dat);
                    stall_errors++;
                end
            end
            stall_prev = wb_stb && !wb_ack;
            prev_adr = wb_adr;
            prev_we = wb_we;
            prev_dat = wb_dat_w;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the core did not halt within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_idle();
        assert (wb_cyc == 1'b0 && wb_stb == 1'b0 && halted == 1'b0) else begin
            $display("[FAIL] wb_cyc %h wb_stb %h halted %h expected 0 around reset",
                wb_cyc, wb_stb, halted);
            error_count++;
        end
    endtask

    task automatic run_program();
        @(posedge clock);
        reset <= 1'b1;
        repeat (16) begin
            @(posedge clock);
            @(negedge clock);
            check_idle();
        end
        @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_idle();
        @(negedge clock);
        check_idle();
        while (!halted) begin
            @(negedge clock);
        end
    endtask

    task automatic compare_memory();
        int a;
        for (a = 0; a < mem_words; a++) begin
            assert (mem[a] == model_mem[a]) else begin
                $display("[FAIL] mem[%h] dut %h expected %h", a, mem[a], model_mem[a]);
                error_count++;
            end
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count + stall_errors;
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = error_count + stall_errors - errors_at_start;
        if (errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors);
        end
    endtask

    task automatic program_test(input int mode, input string name);
        start_test();
        gen_program(mode);
        run_program();
        run_model();
        compare_memory();
        finish_test(name);
    endtask

    initial begin
        int a;

        start_test();
        gen_program(0);
        run_program();
        run_model();
        compare_memory();
        assert (seen_first && first_adr == '0 && !first_we) else begin
            $display("[FAIL] first wb_adr %h wb_we %h expected 0000 0", first_adr, first_we);
            error_count++;
        end
        finish_test("reset and first fetch");

        program_test(0, "alu programs");
        program_test(1, "copy and branch programs");
        program_test(2, "call and return");

        start_test();
        gen_program(3);
        run_program();
        run_model();
        compare_memory();
        repeat (50) begin
            @(negedge clock);
            assert (halted && !wb_cyc) else begin
                $display("[FAIL] halted %h wb_cyc %h after halt", halted, wb_cyc);
                error_count++;
            end
        end
        finish_test("halt on unknown opcode");

        start_test();
        gen_program(1);
        max_wait = 0;
        run_program();
        zero_wait_mem = mem;
        run_model();
        compare_memory();
        max_wait = 3;
        run_program();
        compare_memory();
        for (a = 0; a < mem_words; a++) begin
            assert (mem[a] == zero_wait_mem[a]) else begin
                $display("[FAIL] mem[%h] waited %h zero wait %h", a, mem[a], zero_wait_mem[a]);
                error_count++;
            end
        end
        finish_test("wait states");

        $display("passing tests %0d, failing tests %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
